// ==== logic/mem_bus_pkg.sv ====
package mem_bus_pkg;

    ////////////////////
    // CPU bus geometry
    ////////////////////

    // One bridge per DDR controller
    localparam int NUM_CHANNELS = 2;
    localparam int CHAN_BITS = 1;

    localparam int CPU_ADDR_BITS = 25;
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = 4;

    ////////////////////
    // CPU address word
    ////////////////////

    // Flat word, or channel / controller word address / half bit
    typedef union packed {
        logic [CPU_ADDR_BITS-1:0] flat;
        struct packed {
            logic [CHAN_BITS-1:0] chan;
            logic [CPU_ADDR_BITS-CHAN_BITS-2:0] user_addr;
            logic half;
        } f;
    } cpu_addr_u;

endpackage

// ==== logic/ddr_user_pkg.sv ====
package ddr_user_pkg;

    ////////////////////
    // MIG user port
    ////////////////////

    localparam int USER_ADDR_BITS = 23;
    localparam int CMD_BITS = 3;

    // Command register codes
    localparam logic [CMD_BITS-1:0] CMD_NOP = 3'b000;
    localparam logic [CMD_BITS-1:0] CMD_INIT = 3'b010;
    localparam logic [CMD_BITS-1:0] CMD_WRITE = 3'b100;
    localparam logic [CMD_BITS-1:0] CMD_READ = 3'b110;

    ////////////////////
    // Burst timing
    ////////////////////

    // Edges from the sampled ack to burst_done high
    localparam int BURST_DELAY = 3;

    // burst_done high time for a two word burst
    localparam int BURST_HOLD = 2;

endpackage

// ==== logic/mem_req_if.sv ====
interface mem_req_if;
    import mem_bus_pkg::*;

    // Request held by the router until ready
    logic valid;
    cpu_addr_u addr;
    logic [DATA_BITS-1:0] wdata;
    logic [STRB_BITS-1:0] wstrb;

    // Response with a single cycle ready pulse
    logic ready;
    logic [DATA_BITS-1:0] rdata;

    modport router (
        output valid, addr, wdata, wstrb,
        input ready
    );

    modport bridge (
        input valid, addr, wdata, wstrb,
        output ready, rdata
    );

    modport merge (
        input ready, rdata
    );

endinterface

// ==== logic/req_router.sv ====
module req_router (
    input logic clk90,
    input logic sys_rst180,
    input logic mem_valid,
    input mem_bus_pkg::cpu_addr_u mem_addr,
    input logic [mem_bus_pkg::DATA_BITS-1:0] mem_wdata,
    input logic [mem_bus_pkg::STRB_BITS-1:0] mem_wstrb,
    mem_req_if.router chan [mem_bus_pkg::NUM_CHANNELS]
);
    import mem_bus_pkg::*;

    localparam logic [1:0] RT_IDLE = 2'd0;
    localparam logic [1:0] RT_BUSY = 2'd1;
    localparam logic [1:0] RT_RETIRE = 2'd2;

    logic [1:0] rt_state;
    logic [CHAN_BITS-1:0] grant;
    logic [NUM_CHANNELS-1:0] chan_valid;
    logic [NUM_CHANNELS-1:0] chan_ready;

    genvar i;
    generate
        for (i = 0; i < NUM_CHANNELS; i++) begin : g_chan
            // Only the granted channel sees valid
            assign chan_valid[i] = mem_valid && (rt_state == RT_BUSY) &&
                                   (grant == CHAN_BITS'(i));
            assign chan[i].valid = chan_valid[i];
            assign chan[i].addr = mem_addr;
            assign chan[i].wdata = mem_wdata;
            assign chan[i].wstrb = mem_wstrb;
            assign chan_ready[i] = chan[i].ready;
        end
    endgenerate

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            rt_state <= RT_IDLE;
        end else begin
            case (rt_state)
                RT_IDLE: begin
                    if (mem_valid) begin
                        grant <= mem_addr.f.chan;
                        rt_state <= RT_BUSY;
                    end
                end
                RT_BUSY: begin
                    if (chan_ready[grant]) begin
                        rt_state <= RT_RETIRE;
                    end
                end
                // mem_valid of the finished access is still up here
                RT_RETIRE: begin
                    rt_state <= RT_IDLE;
                end
                default: begin
                    rt_state <= RT_IDLE;
                end
            endcase
        end
    end

    // Only the channel named by the held address is forwarded
    a_one_channel: assert property (
        @(posedge clk90) disable iff (sys_rst180)
        chan_valid != '0 |-> chan_valid == (NUM_CHANNELS'(1) << mem_addr.f.chan)
    ) else $error("router drives a channel other than the addressed one");

    a_aligned: assert property (
        @(posedge clk90) disable iff (sys_rst180)
        mem_valid |-> !mem_addr.flat[0]
    ) else $error("CPU address not aligned to a controller word");

endmodule

// ==== logic/mig_channel_bridge.sv ====
module mig_channel_bridge (
    input logic clk90,
    input logic sys_rst180,
    mem_req_if.bridge req,
    input logic init_done,
    input logic user_cmd_ack,
    input logic user_data_valid,
    input logic auto_refresh_req,
    input logic ar_done,
    input logic [mem_bus_pkg::DATA_BITS-1:0] user_output_data,
    output logic [ddr_user_pkg::CMD_BITS-1:0] user_command_register,
    output logic [ddr_user_pkg::USER_ADDR_BITS-1:0] user_input_address,
    output logic [mem_bus_pkg::DATA_BITS-1:0] user_input_data,
    output logic [mem_bus_pkg::STRB_BITS-1:0] user_data_mask,
    output logic burst_done
);
    import ddr_user_pkg::*;

    localparam logic [3:0] ST_STARTUP = 4'd0;
    localparam logic [3:0] ST_WAIT_INIT = 4'd1;
    localparam logic [3:0] ST_IDLE = 4'd2;
    localparam logic [3:0] ST_WAIT_REFRESH = 4'd3;
    localparam logic [3:0] ST_WRITE_CMD = 4'd4;
    localparam logic [3:0] ST_WRITE_WAIT = 4'd5;
    localparam logic [3:0] ST_WRITE_DONE = 4'd6;
    localparam logic [3:0] ST_READ_CMD = 4'd7;
    localparam logic [3:0] ST_READ_WAIT = 4'd8;
    localparam logic [3:0] ST_READ_DONE = 4'd9;

    localparam logic [1:0] DP_IDLE = 2'd0;
    localparam logic [1:0] DP_WRITE = 2'd1;
    localparam logic [1:0] DP_READ = 2'd2;
    localparam logic [1:0] DP_WAIT = 2'd3;

    logic [3:0] bridge_state;
    logic [1:0] wait_cnt;
    logic [1:0] dp_state;

    ////////////////////
    // Command sequencer
    ////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            bridge_state <= ST_STARTUP;
            user_command_register <= CMD_NOP;
            burst_done <= 1'b0;
            req.ready <= 1'b0;
            wait_cnt <= '0;
        end else begin
            req.ready <= 1'b0;
            case (bridge_state)
                ST_STARTUP: begin
                    if (!init_done) begin
                        user_command_register <= CMD_INIT;
                        bridge_state <= ST_WAIT_INIT;
                    end else begin
                        bridge_state <= ST_IDLE;
                    end
                end
                ST_WAIT_INIT: begin
                    user_command_register <= CMD_NOP;
                    if (init_done) begin
                        bridge_state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    // Refresh has priority over a pending request
                    if (auto_refresh_req) begin
                        bridge_state <= ST_WAIT_REFRESH;
                    end else if (req.valid && !req.ready && !user_cmd_ack) begin
                        // ready still high means the router has not retired yet
                        user_input_address <= req.addr.f.user_addr;
                        if (req.wstrb != '0) begin
                            user_command_register <= CMD_WRITE;
                            bridge_state <= ST_WRITE_CMD;
                        end else begin
                            user_command_register <= CMD_READ;
                            bridge_state <= ST_READ_CMD;
                        end
                    end
                end
                ST_WAIT_REFRESH: begin
                    if (ar_done) begin
                        bridge_state <= ST_IDLE;
                    end
                end
                ST_WRITE_CMD: begin
                    if (user_cmd_ack) begin
                        wait_cnt <= 2'(BURST_DELAY);
                        bridge_state <= ST_WRITE_WAIT;
                    end
                end
                ST_WRITE_WAIT: begin
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b1;
                        wait_cnt <= 2'(BURST_HOLD);
                        bridge_state <= ST_WRITE_DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                ST_WRITE_DONE: begin
                    user_command_register <= CMD_NOP;
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b0;
                        req.ready <= 1'b1;
                        bridge_state <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                ST_READ_CMD: begin
                    if (user_cmd_ack) begin
                        wait_cnt <= 2'(BURST_DELAY);
                        bridge_state <= ST_READ_WAIT;
                    end
                end
                ST_READ_WAIT: begin
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b1;
                        wait_cnt <= 2'(BURST_HOLD);
                        bridge_state <= ST_READ_DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                ST_READ_DONE: begin
                    user_command_register <= CMD_NOP;
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b0;
                        // Controller must release the ack before the next command
                        if (!user_cmd_ack) begin
                            req.ready <= 1'b1;
                            bridge_state <= ST_IDLE;
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                default: begin
                    bridge_state <= ST_STARTUP;
                end
            endcase
        end
    end

    ////////////////////
    // Burst data path
    ////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180 || !init_done) begin
            dp_state <= DP_IDLE;
        end else begin
            case (dp_state)
                DP_IDLE: begin
                    if (user_cmd_ack) begin
                        if (user_command_register == CMD_WRITE) begin
                            user_input_data <= req.wdata;
                            user_data_mask <= req.wstrb;
                            dp_state <= DP_WRITE;
                        end else if (user_command_register == CMD_READ && user_data_valid) begin
                            req.rdata <= user_output_data;
                            dp_state <= DP_READ;
                        end
                    end
                end
                // Second word of the burst is written with an empty mask
                DP_WRITE: begin
                    user_data_mask <= '0;
                    dp_state <= DP_WAIT;
                end
                DP_READ: begin
                    dp_state <= DP_WAIT;
                end
                DP_WAIT: begin
                    if (!user_cmd_ack) begin
                        dp_state <= DP_IDLE;
                    end
                end
                default: begin
                    dp_state <= DP_IDLE;
                end
            endcase
        end
    end

    a_no_cmd_before_init: assert property (
        @(posedge clk90) disable iff (sys_rst180)
        (user_command_register == CMD_WRITE || user_command_register == CMD_READ)
            |-> init_done
    ) else $error("access command before init_done");

    a_burst_done_len: assert property (
        @(posedge clk90) disable iff (sys_rst180)
        $rose(burst_done) |=> burst_done ##1 !burst_done
    ) else $error("burst_done not high for exactly two cycles");

endmodule

// ==== logic/resp_merge.sv ====
module resp_merge (
    input logic clk90,
    input logic sys_rst180,
    mem_req_if.merge chan [mem_bus_pkg::NUM_CHANNELS],
    output logic mem_ready,
    output logic [mem_bus_pkg::DATA_BITS-1:0] mem_rdata
);
    import mem_bus_pkg::*;

    logic [NUM_CHANNELS-1:0] chan_ready;
    logic [DATA_BITS-1:0] chan_rdata [NUM_CHANNELS];
    logic [DATA_BITS-1:0] sel_rdata;

    genvar i;
    generate
        for (i = 0; i < NUM_CHANNELS; i++) begin : g_chan
            assign chan_ready[i] = chan[i].ready;
            assign chan_rdata[i] = chan[i].rdata;
        end
    endgenerate

    // Data of the channel that just finished
    always_comb begin
        sel_rdata = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (chan_ready[k]) begin
                sel_rdata = chan_rdata[k];
            end
        end
    end

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= |chan_ready;
        end
    end

    always_ff @(posedge clk90) begin
        if (|chan_ready) begin
            mem_rdata <= sel_rdata;
        end
    end

    a_single_ready: assert property (
        @(posedge clk90) disable iff (sys_rst180)
        $onehot0(chan_ready)
    ) else $error("two channels finished in the same cycle");

endmodule

// ==== logic/ddr_multi_bridge.sv ====
module ddr_multi_bridge (
    input logic clk90,
    input logic sys_rst180,

    // CPU memory bus
    input logic mem_valid,
    input mem_bus_pkg::cpu_addr_u mem_addr,
    input logic [mem_bus_pkg::DATA_BITS-1:0] mem_wdata,
    input logic [mem_bus_pkg::STRB_BITS-1:0] mem_wstrb,
    output logic mem_ready,
    output logic [mem_bus_pkg::DATA_BITS-1:0] mem_rdata,

    // MIG user ports, one entry per channel
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0] init_done,
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0] user_cmd_ack,
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0] user_data_valid,
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0] auto_refresh_req,
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0] ar_done,
    input logic [mem_bus_pkg::NUM_CHANNELS-1:0][mem_bus_pkg::DATA_BITS-1:0] user_output_data,
    output logic [mem_bus_pkg::NUM_CHANNELS-1:0][ddr_user_pkg::CMD_BITS-1:0]
        user_command_register,
    output logic [mem_bus_pkg::NUM_CHANNELS-1:0][ddr_user_pkg::USER_ADDR_BITS-1:0]
        user_input_address,
    output logic [mem_bus_pkg::NUM_CHANNELS-1:0][mem_bus_pkg::DATA_BITS-1:0] user_input_data,
    output logic [mem_bus_pkg::NUM_CHANNELS-1:0][mem_bus_pkg::STRB_BITS-1:0] user_data_mask,
    output logic [mem_bus_pkg::NUM_CHANNELS-1:0] burst_done
);
    import mem_bus_pkg::*;

    mem_req_if chan [NUM_CHANNELS] ();

    req_router i_router (
        .clk90(clk90),
        .sys_rst180(sys_rst180),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .chan(chan)
    );

    genvar g;
    generate
        for (g = 0; g < NUM_CHANNELS; g++) begin : g_bridge
            mig_channel_bridge i_bridge (
                .clk90(clk90),
                .sys_rst180(sys_rst180),
                .req(chan[g]),
                .init_done(init_done[g]),
                .user_cmd_ack(user_cmd_ack[g]),
                .user_data_valid(user_data_valid[g]),
                .auto_refresh_req(auto_refresh_req[g]),
                .ar_done(ar_done[g]),
                .user_output_data(user_output_data[g]),
                .user_command_register(user_command_register[g]),
                .user_input_address(user_input_address[g]),
                .user_input_data(user_input_data[g]),
                .user_data_mask(user_data_mask[g]),
                .burst_done(burst_done[g])
            );
        end
    endgenerate

    resp_merge i_merge (
        .clk90(clk90),
        .sys_rst180(sys_rst180),
        .chan(chan),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

endmodule

// ==== test/mig_user_model.sv ====
module mig_user_model (
    input logic clk90,
    input logic [ddr_user_pkg::CMD_BITS-1:0] user_command_register,
    input logic [ddr_user_pkg::USER_ADDR_BITS-1:0] user_input_address,
    input logic [31:0] user_input_data,
    input logic [3:0] user_data_mask,
    input logic burst_done,
    output logic init_done,
    output logic user_cmd_ack,
    output logic user_data_valid,
    output logic [31:0] user_output_data,
    output logic auto_refresh_req,
    output logic ar_done,
    output logic model_err
);
    import ddr_user_pkg::*;

    logic [31:0] mem [logic [USER_ADDR_BITS-1:0]];

    // Unwritten words built from the whole word address
    function automatic logic [31:0] fill_word(input logic [USER_ADDR_BITS-1:0] a);
        return {a[7:0] ^ 8'hc3, 1'b0, a};
    endfunction

    function automatic logic [31:0] read_word(input logic [USER_ADDR_BITS-1:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    initial begin
        int n;
        init_done = 1'b0;
        model_err = 1'b0;
        n = 0;
        while (user_command_register !== CMD_INIT && n < 200) begin
            @(posedge clk90);
            n++;
        end
        if (n >= 200) begin
            model_err = 1'b1;
            $display("controller model never saw the init command");
        end
        repeat ($urandom_range(3, 12)) @(posedge clk90);
        #1 init_done = 1'b1;
    end

    ////////////////////
    // Command responder
    ////////////////////
    initial begin
        logic is_wr;
        logic [USER_ADDR_BITS-1:0] addr;
        logic [31:0] word;
        int n;
        user_cmd_ack = 1'b0;
        user_data_valid = 1'b0;
        user_output_data = '0;
        forever begin
            @(posedge clk90);
            if (init_done && !user_cmd_ack &&
                (user_command_register == CMD_WRITE || user_command_register == CMD_READ)) begin
                is_wr = (user_command_register == CMD_WRITE);
                addr = user_input_address;
                repeat ($urandom_range(0, 3)) @(posedge clk90);
                #1 user_cmd_ack = 1'b1;
                if (!is_wr) begin
                    user_data_valid = 1'b1;
                    user_output_data = read_word(addr);
                end
                @(posedge clk90);
                @(posedge clk90);
                // First burst word with mask bits as byte enables
                if (is_wr) begin
                    word = read_word(addr);
                    for (int b = 0; b < 4; b++) begin
                        if (user_data_mask[b]) word[8*b +: 8] = user_input_data[8*b +: 8];
                    end
                    mem[addr] = word;
                end
                #1 user_data_valid = 1'b0;
                n = 0;
                while (!burst_done && n < 50) begin
                    @(posedge clk90);
                    n++;
                end
                while (burst_done && n < 50) begin
                    @(posedge clk90);
                    n++;
                end
                if (n >= 50) begin
                    model_err = 1'b1;
                    $display("burst_done never completed at time %0t", $time);
                end
                #1 user_cmd_ack = 1'b0;
            end
        end
    end

    // Random refresh only while the port looks quiet
    initial begin
        auto_refresh_req = 1'b0;
        ar_done = 1'b0;
        forever begin
            @(posedge clk90);
            if (init_done && !user_cmd_ack && user_command_register == CMD_NOP &&
                $urandom_range(0, 15) == 0) begin
                #1 auto_refresh_req = 1'b1;
                repeat ($urandom_range(2, 6)) @(posedge clk90);
                #1 auto_refresh_req = 1'b0;
                ar_done = 1'b1;
                @(posedge clk90);
                #1 ar_done = 1'b0;
            end
        end
    end

endmodule

// ==== test/tb_ddr_multi_bridge.sv ====
module tb_ddr_multi_bridge;
    import mem_bus_pkg::*;
    import ddr_user_pkg::*;

    logic clk90;
    logic sys_rst180;
    logic mem_valid;
    cpu_addr_u mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0] mem_wstrb;
    logic mem_ready;
    logic [31:0] mem_rdata;
    logic [1:0] init_done, user_cmd_ack, user_data_valid, auto_refresh_req, ar_done;
    logic [1:0] burst_done, model_err, is_access;
    logic [1:0][31:0] user_output_data, user_input_data;
    logic [1:0][2:0] user_command_register;
    logic [1:0][22:0] user_input_address;
    logic [1:0][3:0] user_data_mask;

    int err_cnt = 0;
    int timeout_cnt = 0;
    int init_cnt [2] = '{0, 0};
    logic req_active = 1'b0;
    logic exp_read = 1'b0;
    logic [31:0] exp_rdata = '0;
    cpu_addr_u pool [6];
    logic [31:0] ref_mem [6];

    ddr_multi_bridge i_dut (.*);

    initial begin
        clk90 = 1'b0;
        forever #10 clk90 = ~clk90;
    end

    ////////////////////
    // Controllers and checks per channel
    ////////////////////
    genvar c;
    generate
        for (c = 0; c < 2; c++) begin : g_ch
            mig_user_model i_model (
                .clk90(clk90),
                .user_command_register(user_command_register[c]),
                .user_input_address(user_input_address[c]),
                .user_input_data(user_input_data[c]),
                .user_data_mask(user_data_mask[c]),
                .burst_done(burst_done[c]),
                .init_done(init_done[c]),
                .user_cmd_ack(user_cmd_ack[c]),
                .user_data_valid(user_data_valid[c]),
                .user_output_data(user_output_data[c]),
                .auto_refresh_req(auto_refresh_req[c]),
                .ar_done(ar_done[c]),
                .model_err(model_err[c])
            );
            assign is_access[c] = user_command_register[c] == CMD_WRITE ||
                                  user_command_register[c] == CMD_READ;

            always @(posedge clk90) begin
                if (user_command_register[c] == CMD_INIT) init_cnt[c]++;
            end

            a_init: assert property (@(posedge clk90) disable iff (sys_rst180)
                (user_command_register[c] == CMD_INIT) |=> user_command_register[c] == CMD_NOP)
            else begin
                err_cnt++;
                $display("mismatch at %0t: init held on ch%0d", $time, c);
            end

            // Bit 24 picks the channel, bits 23..1 are the controller word address
            a_route: assert property (@(posedge clk90) disable iff (sys_rst180)
                $rose(is_access[c]) |-> mem_valid && init_done[c] &&
                    int'(mem_addr.flat[24]) == c && user_input_address[c] == mem_addr.flat[23:1])
            else begin
                err_cnt++;
                $display("mismatch at %0t: bad command on ch%0d", $time, c);
            end

            a_burst: assert property (@(posedge clk90) disable iff (sys_rst180)
                $rose(user_cmd_ack[c]) |-> ##4 $rose(burst_done[c]) ##1 burst_done[c]
                    ##1 !burst_done[c])
            else begin
                err_cnt++;
                $display("mismatch at %0t: burst timing ch%0d", $time, c);
            end

            a_wdata: assert property (@(posedge clk90) disable iff (sys_rst180)
                $rose(user_cmd_ack[c]) && user_command_register[c] == CMD_WRITE |->
                    ##1 (user_data_mask[c] == mem_wstrb && user_input_data[c] == mem_wdata)
                    ##1 user_data_mask[c] == 4'h0)
            else begin
                err_cnt++;
                $display("mismatch at %0t: write data ch%0d", $time, c);
            end

            a_refresh: assert property (@(posedge clk90) disable iff (sys_rst180)
                (user_command_register[c] == CMD_NOP && auto_refresh_req[c])
                    |=> user_command_register[c] == CMD_NOP)
            else begin
                err_cnt++;
                $display("mismatch at %0t: cmd in refresh ch%0d", $time, c);
            end
        end
    endgenerate

    a_reset: assert property (@(posedge clk90)
        $fell(sys_rst180) |-> user_command_register == '0 && burst_done == '0 && !mem_ready)
    else begin
        err_cnt++;
        $display("mismatch at %0t: outputs active after reset", $time);
    end

    a_ready: assert property (@(posedge clk90) disable iff (sys_rst180)
        mem_ready |-> req_active ##1 !mem_ready)
    else begin
        err_cnt++;
        $display("mismatch at %0t: extra or long mem_ready", $time);
    end

    a_rdata: assert property (@(posedge clk90) disable iff (sys_rst180)
        mem_ready && exp_read |-> mem_rdata == exp_rdata)
    else begin
        err_cnt++;
        $display("mismatch at %0t: read %h expected %h", $time, mem_rdata, exp_rdata);
    end

    task automatic run_access(input int idx, input logic [3:0] strb, input logic [31:0] data);
        int n;
        exp_read = (strb == 4'h0);
        exp_rdata = ref_mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
        mem_addr = pool[idx];
        mem_wdata = data;
        mem_wstrb = strb;
        mem_valid = 1'b1;
        req_active = 1'b1;
        n = 0;
        do begin
            @(posedge clk90);
            n++;
        end while (!mem_ready && n < 400);
        if (!mem_ready) begin
            timeout_cnt++;
            $display("no mem_ready for the access to %h", pool[idx].flat);
        end
        #1 mem_valid = 1'b0;
        req_active = 1'b0;
        exp_read = 1'b0;
        @(posedge clk90);
        #1;
    endtask

    initial begin
        void'($urandom(32'ha7eeb5f2));
        sys_rst180 = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        for (int i = 0; i < 6; i++) begin
            pool[i].f.chan = 1'(i % 2);
            pool[i].f.user_addr = {20'($urandom), 3'(i)};
            pool[i].f.half = 1'b0;
        end
        repeat (2) @(posedge clk90);
        #1 sys_rst180 = 1'b0;
        for (int i = 0; i < 6; i++) run_access(i, 4'hf, $urandom);
        for (int k = 0; k < 60; k++) begin
            if ($urandom_range(0, 1) == 0) run_access($urandom_range(0, 5), 4'h0, $urandom);
            else run_access($urandom_range(0, 5), 4'($urandom_range(1, 15)), $urandom);
        end
        repeat (5) @(posedge clk90);
        if (init_cnt[0] != 1 || init_cnt[1] != 1) begin
            err_cnt++;
            $display("init command count per channel is not one");
        end
        if (model_err != 2'b00) begin
            err_cnt++;
            $display("controller model reported a stuck handshake");
        end
        $display("errors %0d, timeouts %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/mem_bus_pkg.sv
logic/ddr_user_pkg.sv
logic/mem_req_if.sv
logic/req_router.sv
logic/mig_channel_bridge.sv
logic/resp_merge.sv
logic/ddr_multi_bridge.sv
test/mig_user_model.sv
test/tb_ddr_multi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
verilator --binary --assert --timing --top-module tb_ddr_multi_bridge \
    -f sources.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q "Result: PASSED" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
